// ==== src/alloc_pkg.sv ====
// ==============================
// Shared geometry and types for the local-buffer allocator
// Modules take these by a wildcard import in their header
// ==============================

package alloc_pkg;

	// ==============================
	// Configuration table
	// ==============================
	// Number of input configurations held by the size table
	localparam int N_ICFG = 4;
	// Id width, one extra code so N_ICFG works as an exclusive end
	localparam int ICFG_BW = $clog2(N_ICFG + 1);

	// ==============================
	// Local buffer geometry
	// ==============================
	// Word address width of the local buffer
	localparam int LBW = 10;
	// Words per vector
	localparam int VSIZE = 8;
	// Word offset bits inside one vector
	localparam int CV_BW = $clog2(VSIZE);
	// Vector address width, the part the allocator tracks
	localparam int HBW = LBW - CV_BW;
	// Whole buffer in vectors, one bit wider than a vector address
	localparam logic [HBW:0] CAPACITY = (HBW + 1)'(1 << HBW);

	// ==============================
	// Outstanding block limits
	// ==============================
	// Depth of the address FIFO and limit of blocks not yet seen by DMA
	localparam int LBUF_SIZE = 5;
	// Counter width able to hold 0..LBUF_SIZE
	localparam int SEM_BW = $clog2(LBUF_SIZE + 1);

	// Id sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,
		SEQ_RUN  = 2'd1,
		SEQ_LAST = 2'd2
	} seq_state_e;

endpackage

// ==== src/cfg_size_table.sv ====
// ==============================
// Per-configuration block size registers
// Host writes one size per id, two ports read it back combinationally
// ==============================

module cfg_size_table
	import alloc_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst,
	// Host write port
	input  logic               i_cfg_we,
	input  logic [ICFG_BW-1:0] i_cfg_waddr,
	input  logic [HBW:0]       i_cfg_wsize,
	// Read port for the id being allocated
	input  logic [ICFG_BW-1:0] i_rd_id_a,
	output logic [HBW:0]       o_rd_size_a,
	// Read port for the id being freed
	input  logic [ICFG_BW-1:0] i_rd_id_b,
	output logic [HBW:0]       o_rd_size_b
);

	logic [HBW:0] size_r [N_ICFG];

	// Ids past the table read as an empty block
	function automatic logic [HBW:0] rd_size(input logic [ICFG_BW-1:0] id);
		logic [HBW:0] size;
		size = '0;
		for (int i = 0; i < N_ICFG; i++) begin
			if (id == ICFG_BW'(i)) begin
				size = size_r[i];
			end
		end
		return size;
	endfunction

	// Sizes clear on reset so an unwritten id reserves nothing
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < N_ICFG; i++) begin
				size_r[i] <= '0;
			end
		end else if (i_cfg_we) begin
			for (int i = 0; i < N_ICFG; i++) begin
				if (i_cfg_waddr == ICFG_BW'(i)) begin
					size_r[i] <= i_cfg_wsize;
				end
			end
		end
	end

	assign o_rd_size_a = rd_size(i_rd_id_a);
	assign o_rd_size_b = rd_size(i_rd_id_b);

endmodule

// ==== src/cfg_id_sequencer.sv ====
// ==============================
// Steps configuration ids from begin to exclusive end
// Holds the request ready until the last id is accepted downstream
// ==============================

module cfg_id_sequencer
	import alloc_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst,
	// Allocation request, ready held until ack
	input  logic               i_alloc_rdy,
	output logic               o_alloc_ack,
	input  logic [ICFG_BW-1:0] i_beg_id,
	input  logic [ICFG_BW-1:0] i_end_id,
	// One step per id toward the allocator
	output logic [ICFG_BW-1:0] o_cur_id,
	output logic               o_step_rdy,
	input  logic               i_step_ack
);

	seq_state_e         state_r;
	seq_state_e         state_w;
	logic [ICFG_BW-1:0] id_r;
	logic [ICFG_BW-1:0] id_w;
	logic [ICFG_BW-1:0] id_1;
	logic [ICFG_BW-1:0] id_2;
	logic [ICFG_BW-1:0] beg_1;

	always_comb begin
		id_1    = id_r + 1'b1;
		id_2    = id_r + 2'd2;
		beg_1   = i_beg_id + 1'b1;
		state_w = state_r;
		id_w    = id_r;
		case (state_r)
			// Latch begin id, a one-id range goes straight to LAST
			SEQ_IDLE: begin
				if (i_alloc_rdy) begin
					id_w    = i_beg_id;
					state_w = (beg_1 == i_end_id) ? SEQ_LAST : SEQ_RUN;
				end
			end
			// Advance on each accepted step
			SEQ_RUN: begin
				if (i_step_ack) begin
					id_w    = id_1;
					state_w = (id_2 == i_end_id) ? SEQ_LAST : SEQ_RUN;
				end
			end
			// Last id taken, request is done
			SEQ_LAST: begin
				if (i_step_ack) begin
					state_w = SEQ_IDLE;
				end
			end
			default: state_w = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_r <= SEQ_IDLE;
			id_r    <= '0;
		end else begin
			state_r <= state_w;
			id_r    <= id_w;
		end
	end

	assign o_cur_id    = id_r;
	assign o_step_rdy  = state_r != SEQ_IDLE;
	// Request ack lines up with the last step ack
	assign o_alloc_ack = (state_r == SEQ_LAST) && i_step_ack;

endmodule

// ==== src/slot_semaphore.sv ====
// ==============================
// Counts blocks reserved but not yet taken by the DMA side
// Full at LBUF_SIZE, empty at zero
// ==============================

module slot_semaphore
	import alloc_pkg::*;
(
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_inc,
	input  logic i_dec,
	output logic o_full,
	output logic o_empty
);

	logic [SEM_BW-1:0] cnt_r;

	// Inc and dec together leave the count alone
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			cnt_r <= '0;
		end else if (i_inc && !i_dec) begin
			cnt_r <= cnt_r + 1'b1;
		end else if (!i_inc && i_dec) begin
			cnt_r <= cnt_r - 1'b1;
		end
	end

	assign o_full  = cnt_r == SEM_BW'(LBUF_SIZE);
	assign o_empty = cnt_r == '0;

endmodule

// ==== src/linear_fifo.sv ====
// ==============================
// Shift FIFO of reserved blocks, head at entry 0
// Each entry is a vector address and the block size in vectors
// ==============================

module linear_fifo
	import alloc_pkg::*;
(
	input  logic           i_clk,
	input  logic           i_rst,
	// Push side
	input  logic           i_push,
	input  logic [HBW-1:0] i_push_hi,
	input  logic [HBW:0]   i_push_size,
	// Pop side
	input  logic           i_pop,
	output logic           o_empty,
	output logic           o_full,
	output logic [HBW-1:0] o_head_hi,
	output logic [HBW:0]   o_head_size
);

	logic [HBW-1:0]    hi_r   [LBUF_SIZE];
	logic [HBW:0]      size_r [LBUF_SIZE];
	logic [SEM_BW-1:0] cnt_r;
	logic [SEM_BW-1:0] wr_idx;

	// ==============================
	// Occupancy
	// ==============================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			cnt_r <= '0;
		end else if (i_push && !i_pop) begin
			cnt_r <= cnt_r + 1'b1;
		end else if (!i_push && i_pop) begin
			cnt_r <= cnt_r - 1'b1;
		end
	end

	// A push during a pop lands in the slot freed by the shift
	assign wr_idx = i_pop ? cnt_r - 1'b1 : cnt_r;

	// ==============================
	// Storage
	// ==============================
	always_ff @(posedge i_clk) begin
		// Move everything one step toward the head
		if (i_pop) begin
			for (int i = 0; i < LBUF_SIZE - 1; i++) begin
				hi_r[i]   <= hi_r[i + 1];
				size_r[i] <= size_r[i + 1];
			end
		end
		// Later assignment wins over the shift at wr_idx
		if (i_push) begin
			hi_r[wr_idx]   <= i_push_hi;
			size_r[wr_idx] <= i_push_size;
		end
	end

	assign o_empty     = cnt_r == '0;
	assign o_full      = cnt_r == SEM_BW'(LBUF_SIZE);
	assign o_head_hi   = hi_r[0];
	assign o_head_size = size_r[0];

endmodule

// ==== src/buffer_allocator.sv ====
// ==============================
// Allocator core for the circular local buffer
// Reserves space per id, queues block addresses, releases them
// once enough vectors have been written, and takes frees back
// ==============================

module buffer_allocator
	import alloc_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst,
	// Step from the id sequencer
	input  logic [ICFG_BW-1:0] i_cur_id,
	input  logic [HBW:0]       i_cur_size,
	input  logic               i_step_rdy,
	output logic               o_step_ack,
	// Space return
	input  logic               i_free_dval,
	input  logic [HBW:0]       i_free_size,
	// One vector written into SRAM per pulse
	input  logic               i_we_dval,
	// Linear address output
	output logic               o_linear_rdy,
	input  logic               i_linear_ack,
	output logic [LBW-1:0]     o_linear,
	// DMA notification, one token per block
	output logic               o_allocated_rdy,
	input  logic               i_allocated_ack
);

	logic [HBW-1:0] wr_ptr_r;
	logic [HBW:0]   capacity_r;
	logic [HBW:0]   capacity_w;
	logic [HBW:0]   valid_num_r;
	logic [HBW:0]   valid_num_w;
	logic [HBW:0]   step_size;
	logic           has_space;
	logic           sem_full;
	logic           sem_empty;
	logic           fifo_full;
	logic           fifo_empty;
	logic [HBW-1:0] head_hi;
	logic [HBW:0]   head_size;
	logic           filled;
	logic           lin_take;
	logic           dma_take;

	// ==============================
	// Step gating
	// ==============================
	// Ids outside the table reserve nothing
	assign step_size = (i_cur_id < ICFG_BW'(N_ICFG)) ? i_cur_size : '0;

	always_comb begin
		has_space  = capacity_r >= step_size;
		// FIFO room also matters when DMA acks run ahead of linear acks
		o_step_ack = i_step_rdy && has_space && !sem_full && !fifo_full;
	end

	// Running write pointer, wraps at CAPACITY by width
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr_r <= '0;
		end else if (o_step_ack) begin
			wr_ptr_r <= wr_ptr_r + step_size[HBW-1:0];
		end
	end

	// ==============================
	// Outstanding blocks and address queue
	// ==============================
	slot_semaphore u_sem (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_inc   (o_step_ack),
		.i_dec   (dma_take),
		.o_full  (sem_full),
		.o_empty (sem_empty)
	);

	linear_fifo u_fifo (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_push      (o_step_ack),
		.i_push_hi   (wr_ptr_r),
		.i_push_size (step_size),
		.i_pop       (lin_take),
		.o_empty     (fifo_empty),
		.o_full      (fifo_full),
		.o_head_hi   (head_hi),
		.o_head_size (head_size)
	);

	// DMA may start as soon as anything is reserved
	assign o_allocated_rdy = !sem_empty;
	assign dma_take        = o_allocated_rdy && i_allocated_ack;

	// Head leaves only when SRAM holds the whole block
	assign filled       = valid_num_r >= head_size;
	assign o_linear_rdy = !fifo_empty && filled;
	assign lin_take     = o_linear_rdy && i_linear_ack;
	// Word address, vector aligned
	assign o_linear     = {head_hi, {CV_BW{1'b0}}};

	// ==============================
	// Resource counters
	// ==============================
	// Free capacity, a step and a free may land together
	always_comb begin
		case ({o_step_ack, i_free_dval})
			2'b00:   capacity_w = capacity_r;
			2'b01:   capacity_w = capacity_r + i_free_size;
			2'b10:   capacity_w = capacity_r - step_size;
			default: capacity_w = capacity_r - step_size + i_free_size;
		endcase
	end

	// Written vectors not yet claimed by a released block
	always_comb begin
		case ({lin_take, i_we_dval})
			2'b00:   valid_num_w = valid_num_r;
			2'b01:   valid_num_w = valid_num_r + 1'b1;
			2'b10:   valid_num_w = valid_num_r - head_size;
			default: valid_num_w = valid_num_r - head_size + 1'b1;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			capacity_r  <= CAPACITY;
			valid_num_r <= '0;
		end else begin
			capacity_r  <= capacity_w;
			valid_num_r <= valid_num_w;
		end
	end

endmodule

// ==== src/alloc_top.sv ====
// ==============================
// Local-buffer space allocator, top level
// Size table and id sequencer feeding the allocator core
// ==============================

module alloc_top
	import alloc_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst,
	// Host size writes
	input  logic               i_cfg_we,
	input  logic [ICFG_BW-1:0] i_cfg_waddr,
	input  logic [HBW:0]       i_cfg_wsize,
	// Allocation request over an id range
	input  logic               i_alloc_rdy,
	output logic               o_alloc_ack,
	input  logic [ICFG_BW-1:0] i_beg_id,
	input  logic [ICFG_BW-1:0] i_end_id,
	// Linear address consumer
	output logic               o_linear_rdy,
	input  logic               i_linear_ack,
	output logic [LBW-1:0]     o_linear,
	// DMA notification
	output logic               o_allocated_rdy,
	input  logic               i_allocated_ack,
	// SRAM written strobe and frees
	input  logic               i_we_dval,
	input  logic               i_free_dval,
	input  logic [ICFG_BW-1:0] i_free_id
);

	logic [ICFG_BW-1:0] s_cur_id;
	logic [HBW:0]       s_cur_size;
	logic [HBW:0]       s_free_size;
	logic               s_step_rdy;
	logic               s_step_ack;

	// Port a follows the id in flight, port b the id being freed
	cfg_size_table u_table (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_cfg_we    (i_cfg_we),
		.i_cfg_waddr (i_cfg_waddr),
		.i_cfg_wsize (i_cfg_wsize),
		.i_rd_id_a   (s_cur_id),
		.o_rd_size_a (s_cur_size),
		.i_rd_id_b   (i_free_id),
		.o_rd_size_b (s_free_size)
	);

	cfg_id_sequencer u_seq (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_alloc_rdy (i_alloc_rdy),
		.o_alloc_ack (o_alloc_ack),
		.i_beg_id    (i_beg_id),
		.i_end_id    (i_end_id),
		.o_cur_id    (s_cur_id),
		.o_step_rdy  (s_step_rdy),
		.i_step_ack  (s_step_ack)
	);

	buffer_allocator u_alloc (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_cur_id        (s_cur_id),
		.i_cur_size      (s_cur_size),
		.i_step_rdy      (s_step_rdy),
		.o_step_ack      (s_step_ack),
		.i_free_dval     (i_free_dval),
		.i_free_size     (s_free_size),
		.i_we_dval       (i_we_dval),
		.o_linear_rdy    (o_linear_rdy),
		.i_linear_ack    (i_linear_ack),
		.o_linear        (o_linear),
		.o_allocated_rdy (o_allocated_rdy),
		.i_allocated_ack (i_allocated_ack)
	);

endmodule

// ==== dv/tb_alloc_top.sv ====
// ==============================
// Trace-driven testbench for the local-buffer allocator
// Commands come from the trace file, a cycle model checks every edge
// ==============================

module tb_alloc_top
	import alloc_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic               i_clk;
	logic               i_rst;
	logic               i_cfg_we;
	logic [ICFG_BW-1:0] i_cfg_waddr;
	logic [HBW:0]       i_cfg_wsize;
	logic               i_alloc_rdy;
	logic               o_alloc_ack;
	logic [ICFG_BW-1:0] i_beg_id;
	logic [ICFG_BW-1:0] i_end_id;
	logic               o_linear_rdy;
	logic               i_linear_ack;
	logic [LBW-1:0]     o_linear;
	logic               o_allocated_rdy;
	logic               i_allocated_ack;
	logic               i_we_dval;
	logic               i_free_dval;
	logic [ICFG_BW-1:0] i_free_id;

	// Trace commands
	byte         t_op [$];
	int          t_a  [$];
	int          t_b  [$];
	// Reference model state
	int          m_size [N_ICFG];
	int          m_ptr   = 0;
	int          m_cap   = int'(CAPACITY);
	int          m_valid = 0;
	int          m_sem   = 0;
	int          m_cur   = 0;
	int          m_end   = 0;
	bit          m_busy  = 1'b0;
	int          q_addr [$];
	int          q_size [$];
	// Run control
	int          errors      = 0;
	int          cycle_cnt   = 0;
	int          cycle_limit = 1000;
	bit          pending     = 1'b0;
	bit          ack_seen    = 1'b0;
	int unsigned lcg_state   = 12257;

	alloc_top DUT (.*);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// Watchdog, limit set from the trace length
	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("MISMATCH t=%0t %s got 0x%0h exp 0x%0h", $time, name, got, exp);
		errors++;
	endtask

	// ==============================
	// Cycle model, run at each rising edge
	// ==============================
	task automatic update_model();
		int need;
		bit was_busy;
		bit step;
		bit last;
		bit exp_lin;
		bit exp_dma;
		was_busy = m_busy;
		need     = (m_cur < N_ICFG) ? m_size[m_cur] : 0;
		// An id goes when space, outstanding count and queue room all allow
		step     = m_busy && m_cap >= need && m_sem < LBUF_SIZE && q_addr.size() < LBUF_SIZE;
		last     = step && (m_cur + 1 == m_end);
		exp_lin  = 1'b0;
		if (q_addr.size() != 0) begin
			exp_lin = m_valid >= q_size[0];
		end
		exp_dma  = m_sem != 0;
		if (o_alloc_ack !== last) report_mismatch("o_alloc_ack", o_alloc_ack, last);
		if (o_linear_rdy !== exp_lin) report_mismatch("o_linear_rdy", o_linear_rdy, exp_lin);
		if (o_allocated_rdy !== exp_dma) report_mismatch("o_allocated_rdy", o_allocated_rdy, exp_dma);
		if (exp_lin && o_linear !== LBW'(q_addr[0])) report_mismatch("o_linear", o_linear, q_addr[0]);
		if (o_alloc_ack === 1'b1) ack_seen = 1'b1;
		// Released block claims its written vectors
		if (exp_lin && i_linear_ack) begin
			m_valid -= q_size[0];
			void'(q_addr.pop_front());
			void'(q_size.pop_front());
		end
		if (i_we_dval) m_valid++;
		// Address is the running sum of sizes, wrapped, in words
		if (step) begin
			q_addr.push_back(m_ptr * VSIZE);
			q_size.push_back(need);
			m_ptr = (m_ptr + need) % int'(CAPACITY);
			m_cap -= need;
			m_cur++;
			m_sem++;
			if (last) m_busy = 1'b0;
		end
		if (i_free_dval) m_cap += m_size[i_free_id];
		if (exp_dma && i_allocated_ack) m_sem--;
		// Request is latched from idle, first step comes a cycle later
		if (!was_busy && i_alloc_rdy) begin
			m_busy = 1'b1;
			m_cur  = i_beg_id;
			m_end  = i_end_id;
		end
		if (i_cfg_we) m_size[i_cfg_waddr] = i_cfg_wsize;
	endtask

	// One clock, strobes cleared at the falling edge
	task automatic run_cycle();
		@(posedge i_clk);
		update_model();
		@(negedge i_clk);
		i_cfg_we        = 1'b0;
		i_we_dval       = 1'b0;
		i_free_dval     = 1'b0;
		i_linear_ack    = 1'b0;
		i_allocated_ack = 1'b0;
		if (ack_seen) begin
			i_alloc_rdy = 1'b0;
			pending     = 1'b0;
			ack_seen    = 1'b0;
		end
	endtask

	task automatic read_trace();
		int    fd;
		int    a;
		int    b;
		string line;
		fd = $fopen("dv/alloc_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file dv/alloc_trace.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				a    = 0;
				b    = 0;
				void'($fgets(line, fd));
				// Skip comments and blank lines
				if (line.len() > 1 && line.getc(0) != "#") begin
					void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
					t_op.push_back(line.getc(0));
					t_a.push_back(a);
					t_b.push_back(b);
				end
			end
			$fclose(fd);
		end
	endtask

	// ==============================
	// Trace commands
	// ==============================
	task automatic run_command(input byte op, input int a, input int b);
		case (op)
			"S": begin
				i_cfg_we    = 1'b1;
				i_cfg_waddr = ICFG_BW'(a);
				i_cfg_wsize = (HBW + 1)'(b);
				run_cycle();
			end
			// A waits for the ack, B leaves the request pending
			"A", "B": begin
				while (pending) run_cycle();
				i_alloc_rdy = 1'b1;
				i_beg_id    = ICFG_BW'(a);
				i_end_id    = ICFG_BW'(b);
				pending     = 1'b1;
				if (op == "A") begin
					while (pending) run_cycle();
				end
			end
			"D": begin
				while (pending) run_cycle();
			end
			"V": begin
				repeat (a) begin
					i_we_dval = 1'b1;
					run_cycle();
				end
			end
			"F": begin
				i_free_dval = 1'b1;
				i_free_id   = ICFG_BW'(a);
				run_cycle();
			end
			"L": begin
				while (!o_linear_rdy) run_cycle();
				if (o_linear !== LBW'(a)) report_mismatch("o_linear", o_linear, a);
				i_linear_ack = 1'b1;
				run_cycle();
			end
			"K": begin
				repeat (a) begin
					while (!o_allocated_rdy) run_cycle();
					i_allocated_ack = 1'b1;
					run_cycle();
				end
			end
			"W": begin
				repeat (a) run_cycle();
			end
			default: begin
				$display("Unknown trace opcode %c", op);
				errors++;
			end
		endcase
	endtask

	initial begin
		int n_before;
		int gap;
		i_rst           = 1'b1;
		i_cfg_we        = 1'b0;
		i_cfg_waddr     = '0;
		i_cfg_wsize     = '0;
		i_alloc_rdy     = 1'b0;
		i_beg_id        = '0;
		i_end_id        = '0;
		i_linear_ack    = 1'b0;
		i_allocated_ack = 1'b0;
		i_we_dval       = 1'b0;
		i_free_dval     = 1'b0;
		i_free_id       = '0;
		foreach (m_size[i]) m_size[i] = 0;
		read_trace();
		cycle_limit = (t_op.size() + 1) * 64;
		repeat (4) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		// Handshake outputs idle out of reset
		n_before = errors;
		if (o_alloc_ack !== 1'b0) report_mismatch("o_alloc_ack", o_alloc_ack, 0);
		if (o_linear_rdy !== 1'b0) report_mismatch("o_linear_rdy", o_linear_rdy, 0);
		if (o_allocated_rdy !== 1'b0) report_mismatch("o_allocated_rdy", o_allocated_rdy, 0);
		$display("%0t test 0 reset %s", $time, (errors == n_before) ? "ok" : "FAILED");
		for (int i = 0; i < t_op.size(); i++) begin
			n_before = errors;
			// Random idle gap between commands
			gap = int'((lcg_next() >> 16) % 4);
			repeat (gap) run_cycle();
			run_command(t_op[i], t_a[i], t_b[i]);
			$display("%0t test %0d %c %0h %0h %s", $time, i + 1, t_op[i], t_a[i], t_b[i],
				(errors == n_before) ? "ok" : "FAILED");
		end
		repeat (4) run_cycle();
		$display("%0d tests run, %0d errors", t_op.size() + 1, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== dv/alloc_trace.txt ====
# Columns: opcode, then hex operands. S id size, A beg end (waits for ack), B beg end (pending)
# D wait for pending ack, V n writes, F id free, L expected address, K n dma acks, W n idle
S 0 20
S 1 30
S 2 10
S 3 28
A 0 3
V 1f
V 1
L 000
V 40
L 100
L 280
B 3 4
W 8
F 0
D
V 28
L 300
F 1
F 2
B 0 2
W 8
K 5
D
V 50
L 040
L 140
K 1
W 4

// ==== tb.f ====
src/alloc_pkg.sv
src/cfg_size_table.sv
src/cfg_id_sequencer.sv
src/slot_semaphore.sv
src/linear_fifo.sv
src/buffer_allocator.sv
src/alloc_top.sv
dv/tb_alloc_top.sv

// ==== Makefile ====
# Verilator flow for the local-buffer allocator

VERILATOR  ?= verilator
FILELIST   ?= tb.f
TOP        ?= tb_alloc_top
RTL_TOP    ?= alloc_top
OBJ_DIR    ?= obj_dir
SIM_FLAGS  ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall -Wno-fatal
RTL_SRCS   ?= $(filter src/%,$(shell cat $(FILELIST)))
PASS_TEXT  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
